// File: hw/tetris_pkg.sv
package tetris_pkg;

    // board geometry
    localparam int NUM_COLS = 10;
    localparam int NUM_ROWS = 15;
    localparam int COL_W    = 4;
    localparam int ROW_W    = 4;

    localparam logic [COL_W-1:0] SPAWN_COL = 4'd5;

    // score saturates at the winning value
    localparam int                 SCORE_W   = 4;
    localparam logic [SCORE_W-1:0] MAX_SCORE = 4'd10;

    typedef enum logic [1:0] {
        PIECE_BAR    = 2'd0,
        PIECE_SKEW   = 2'd1,
        PIECE_SQUARE = 2'd2
    } piece_kind_e;

    // one placement of a piece, origin cell plus rotation
    typedef struct packed {
        piece_kind_e      kind;
        logic [1:0]       rot;
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] row;
    } piece_t;

    typedef struct packed {
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] row;
    } cell_t;

    typedef struct packed {
        cell_t c0;
        cell_t c1;
        cell_t c2;
        cell_t c3;
    } piece_cells_t;

    typedef logic [NUM_COLS-1:0] row_mask_t;

    // left, right, rotate are single-cycle presses
    typedef struct packed {
        logic left;
        logic right;
        logic rotate;
        logic drop;
    } btn_events_t;

endpackage

// File: hw/button_conditioner.sv
`timescale 1ns/100ps

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 1_000_000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    btn_left,
    input  logic                    btn_right,
    input  logic                    btn_rotate,
    input  logic                    btn_drop,
    output tetris_pkg::btn_events_t events
);

    localparam int TICK_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    // bit order left, right, rotate, drop
    logic [3:0]        sync_q1;
    logic [3:0]        sync_q2;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic [2:0]        sample;
    logic [2:0]        sample_prev;
    logic [2:0]        press;

    assign tick = (tick_cnt == TICK_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q1     <= '0;
            sync_q2     <= '0;
            tick_cnt    <= '0;
            sample      <= '0;
            sample_prev <= '0;
        end else begin
            sync_q1 <= {btn_left, btn_right, btn_rotate, btn_drop};
            sync_q2 <= sync_q1;
            if (tick) begin
                tick_cnt    <= '0;
                sample      <= sync_q2[3:1];
                sample_prev <= sample;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // rising edge between two consecutive samples
    assign press = {3{tick}} & sample & ~sample_prev;

    // drop repeats once per tick while held
    assign events = tetris_pkg::btn_events_t'{
        left:   press[2],
        right:  press[1],
        rotate: press[0],
        drop:   tick & sync_q2[0]
    };

endmodule

// File: hw/piece_cells.sv
`timescale 1ns/100ps

module piece_cells (
    input  tetris_pkg::piece_t       piece,
    output tetris_pkg::piece_cells_t cells
);

    logic [tetris_pkg::COL_W-1:0] c;
    logic [tetris_pkg::ROW_W-1:0] r;

    assign c = piece.col;
    assign r = piece.row;

    // cells past an edge wrap to an out-of-range coordinate
    always_comb begin
        cells = '{c0: '{c, r}, c1: '{c, r}, c2: '{c, r}, c3: '{c, r}};
        case (piece.kind)
            tetris_pkg::PIECE_BAR: begin
                if (piece.rot[0]) begin
                    // vertical
                    cells.c0 = '{c, r - 1'b1};
                    cells.c1 = '{c, r};
                    cells.c2 = '{c, r + 1'b1};
                    cells.c3 = '{c, r + 2'd2};
                end else begin
                    cells.c0 = '{c - 1'b1, r};
                    cells.c1 = '{c, r};
                    cells.c2 = '{c + 1'b1, r};
                    cells.c3 = '{c + 2'd2, r};
                end
            end
            tetris_pkg::PIECE_SKEW: begin
                if (piece.rot[0]) begin
                    cells.c0 = '{c, r - 1'b1};
                    cells.c1 = '{c, r};
                    cells.c2 = '{c - 1'b1, r};
                    cells.c3 = '{c - 1'b1, r + 1'b1};
                end else begin
                    cells.c0 = '{c - 1'b1, r};
                    cells.c1 = '{c, r};
                    cells.c2 = '{c, r + 1'b1};
                    cells.c3 = '{c + 1'b1, r + 1'b1};
                end
            end
            tetris_pkg::PIECE_SQUARE: begin
                // same shape at every rotation
                cells.c0 = '{c, r};
                cells.c1 = '{c + 1'b1, r};
                cells.c2 = '{c, r + 1'b1};
                cells.c3 = '{c + 1'b1, r + 1'b1};
            end
            default: begin
                cells = '{c0: '{c, r}, c1: '{c, r}, c2: '{c, r}, c3: '{c, r}};
            end
        endcase
    end

endmodule

// File: hw/playfield.sv
`timescale 1ns/100ps

module playfield (
    input  logic                           clk,
    input  logic                           reset,
    input  tetris_pkg::piece_t             candidate,
    input  logic                           lock_req,
    input  logic                           clear_req,
    input  logic                           board_clear,
    input  logic [tetris_pkg::ROW_W-1:0]   view_row,
    output logic                           fits,
    output logic [tetris_pkg::SCORE_W-1:0] score,
    output logic                           win,
    output tetris_pkg::row_mask_t          view_locked
);

    tetris_pkg::row_mask_t          board [tetris_pkg::NUM_ROWS];
    tetris_pkg::row_mask_t          compacted [tetris_pkg::NUM_ROWS];
    tetris_pkg::piece_cells_t       cand_cells;
    tetris_pkg::cell_t [3:0]        cell_vec;
    logic [3:0]                     cell_in;
    logic [3:0]                     cell_ok;
    logic [tetris_pkg::SCORE_W:0]   rows_cleared;
    logic [tetris_pkg::SCORE_W:0]   score_sum;

    piece_cells u_cand_cells (
        .piece (candidate),
        .cells (cand_cells)
    );

    assign cell_vec = {cand_cells.c3, cand_cells.c2, cand_cells.c1, cand_cells.c0};

    // fit query, every cell on the board and empty
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cell_in[i] = (cell_vec[i].col < tetris_pkg::NUM_COLS) &&
                         (cell_vec[i].row < tetris_pkg::NUM_ROWS);
            cell_ok[i] = 1'b0;
            if (cell_in[i]) begin
                cell_ok[i] = ~board[cell_vec[i].row][cell_vec[i].col];
            end
        end
    end

    assign fits = &cell_ok;

    // drop full rows, bottom up, empty rows enter at the top
    always_comb begin
        int dst;
        dst = tetris_pkg::NUM_ROWS - 1;
        rows_cleared = '0;
        for (int r = 0; r < tetris_pkg::NUM_ROWS; r++) begin
            compacted[r] = '0;
        end
        for (int src = tetris_pkg::NUM_ROWS - 1; src >= 0; src--) begin
            if (&board[src]) begin
                rows_cleared = rows_cleared + 1'b1;
            end else begin
                compacted[dst] = board[src];
                dst = dst - 1;
            end
        end
    end

    assign score_sum = {1'b0, score} + rows_cleared;

    always_ff @(posedge clk) begin
        if (reset || board_clear) begin
            for (int r = 0; r < tetris_pkg::NUM_ROWS; r++) begin
                board[r] <= '0;
            end
            score <= '0;
        end else if (clear_req) begin
            for (int r = 0; r < tetris_pkg::NUM_ROWS; r++) begin
                board[r] <= compacted[r];
            end
            if (score_sum > tetris_pkg::MAX_SCORE) begin
                score <= tetris_pkg::MAX_SCORE;
            end else begin
                score <= score_sum[tetris_pkg::SCORE_W-1:0];
            end
        end else if (lock_req) begin
            for (int i = 0; i < 4; i++) begin
                if (cell_in[i]) begin
                    board[cell_vec[i].row][cell_vec[i].col] <= 1'b1;
                end
            end
        end
    end

    assign win = (score == tetris_pkg::MAX_SCORE);

    assign view_locked = (view_row < tetris_pkg::NUM_ROWS) ? board[view_row] : '0;

endmodule

// File: hw/game_control.sv
`timescale 1ns/100ps

module game_control #(
    parameter int GRAVITY_CYCLES = 50_000_000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  tetris_pkg::btn_events_t events,
    input  logic                    fits,
    input  logic                    win,
    output tetris_pkg::piece_t      candidate,
    output logic                    lock_req,
    output logic                    clear_req,
    output logic                    board_clear,
    output tetris_pkg::piece_t      piece,
    output logic                    piece_active
);

    localparam int GRAV_W = (GRAVITY_CYCLES > 1) ? $clog2(GRAVITY_CYCLES) : 1;

    logic [GRAV_W-1:0]       grav_cnt;
    logic                    grav_tick;
    tetris_pkg::piece_kind_e next_kind;
    tetris_pkg::piece_kind_e following_kind;
    logic                    clear_pending;
    logic                    busy;
    logic                    try_spawn;
    logic                    try_move;
    logic                    lock_on_fail;
    logic                    restart;

    assign grav_tick = (grav_cnt == GRAV_W'(GRAVITY_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset || grav_tick) begin
            grav_cnt <= '0;
        end else begin
            grav_cnt <= grav_cnt + 1'b1;
        end
    end

    // lock cycle and clear cycle hold off every move
    assign busy = lock_req | clear_pending;
    assign clear_req = clear_pending;

    // one candidate per cycle, gravity first
    always_comb begin
        candidate    = piece;
        try_spawn    = 1'b0;
        try_move     = 1'b0;
        lock_on_fail = 1'b0;
        if (!win && !busy) begin
            if (!piece_active) begin
                if (grav_tick) begin
                    try_spawn      = 1'b1;
                    candidate.kind = next_kind;
                    candidate.rot  = 2'd0;
                    candidate.col  = tetris_pkg::SPAWN_COL;
                    candidate.row  = '0;
                end
            end else if (grav_tick) begin
                try_move      = 1'b1;
                lock_on_fail  = 1'b1;
                candidate.row = piece.row + 1'b1;
            end else if (events.left) begin
                try_move      = 1'b1;
                candidate.col = piece.col - 1'b1;
            end else if (events.right) begin
                try_move      = 1'b1;
                candidate.col = piece.col + 1'b1;
            end else if (events.rotate) begin
                try_move      = 1'b1;
                candidate.rot = piece.rot + 1'b1;
            end else if (events.drop) begin
                try_move      = 1'b1;
                lock_on_fail  = 1'b1;
                candidate.row = piece.row + 1'b1;
            end
        end
    end

    // new game on rotate after a win, or when a spawn is blocked
    assign restart     = win & events.rotate & ~busy;
    assign board_clear = restart | (try_spawn & ~fits);

    always_comb begin
        case (next_kind)
            tetris_pkg::PIECE_BAR:  following_kind = tetris_pkg::PIECE_SKEW;
            tetris_pkg::PIECE_SKEW: following_kind = tetris_pkg::PIECE_SQUARE;
            default:                following_kind = tetris_pkg::PIECE_BAR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            piece         <= tetris_pkg::piece_t'{
                kind: tetris_pkg::PIECE_BAR,
                rot:  2'd0,
                col:  tetris_pkg::SPAWN_COL,
                row:  '0
            };
            piece_active  <= 1'b0;
            next_kind     <= tetris_pkg::PIECE_BAR;
            lock_req      <= 1'b0;
            clear_pending <= 1'b0;
        end else begin
            lock_req      <= 1'b0;
            clear_pending <= lock_req;
            if (board_clear) begin
                piece_active <= 1'b0;
                next_kind    <= tetris_pkg::PIECE_BAR;
            end else if ((try_spawn || try_move) && fits) begin
                piece <= candidate;
                if (try_spawn) begin
                    piece_active <= 1'b1;
                    next_kind    <= following_kind;
                end
            end else if (try_move && lock_on_fail) begin
                // piece keeps its placement so the lock cycle writes it
                lock_req     <= 1'b1;
                piece_active <= 1'b0;
            end
        end
    end

endmodule

// File: hw/row_view.sv
`timescale 1ns/100ps

module row_view (
    input  tetris_pkg::piece_t           piece,
    input  logic                         piece_active,
    input  logic [tetris_pkg::ROW_W-1:0] row_sel,
    output tetris_pkg::row_mask_t        active_row
);

    tetris_pkg::piece_cells_t cells;
    tetris_pkg::cell_t [3:0]  cell_vec;

    piece_cells u_piece_cells (
        .piece (piece),
        .cells (cells)
    );

    assign cell_vec = {cells.c3, cells.c2, cells.c1, cells.c0};

    // mark piece cells on the selected row
    always_comb begin
        active_row = '0;
        for (int i = 0; i < 4; i++) begin
            if (piece_active && (cell_vec[i].row == row_sel) &&
                (cell_vec[i].col < tetris_pkg::NUM_COLS)) begin
                active_row[cell_vec[i].col] = 1'b1;
            end
        end
    end

endmodule

// File: hw/score_display.sv
`timescale 1ns/100ps

module score_display #(
    parameter int SCAN_CYCLES = 100_000
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [tetris_pkg::SCORE_W-1:0] score,
    output logic [6:0]                     seg,
    output logic [1:0]                     an
);

    localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

    logic [SCAN_W-1:0] scan_cnt;
    logic              digit_sel;
    logic [3:0]        ones;
    logic [3:0]        tens;
    logic [3:0]        digit;

    // digit_sel 0 shows ones, 1 shows tens
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt  <= '0;
            digit_sel <= 1'b0;
        end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
            scan_cnt  <= '0;
            digit_sel <= ~digit_sel;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign tens  = (score > 4'd9) ? 4'd1 : 4'd0;
    assign ones  = (score > 4'd9) ? (score - 4'd10) : score;
    assign digit = digit_sel ? tens : ones;
    assign an    = digit_sel ? 2'b01 : 2'b10;

    // active low, bit order g f e d c b a
    always_comb begin
        case (digit)
            4'd0:    seg = 7'b1000000;
            4'd1:    seg = 7'b1111001;
            4'd2:    seg = 7'b0100100;
            4'd3:    seg = 7'b0110000;
            4'd4:    seg = 7'b0011001;
            4'd5:    seg = 7'b0010010;
            4'd6:    seg = 7'b0000010;
            4'd7:    seg = 7'b1111000;
            4'd8:    seg = 7'b0000000;
            4'd9:    seg = 7'b0010000;
            default: seg = 7'b1111111;
        endcase
    end

endmodule

// File: hw/tetris_top.sv
`timescale 1ns/100ps

module tetris_top #(
    parameter int DEBOUNCE_CYCLES = 1_000_000,
    parameter int GRAVITY_CYCLES  = 50_000_000,
    parameter int SCAN_CYCLES     = 100_000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         btn_left,
    input  logic                         btn_right,
    input  logic                         btn_rotate,
    input  logic                         btn_drop,
    input  logic [tetris_pkg::ROW_W-1:0] row_sel,
    output tetris_pkg::row_mask_t        locked_row,
    output tetris_pkg::row_mask_t        active_row,
    output logic [6:0]                   seg,
    output logic [1:0]                   an,
    output logic                         score_win
);

    tetris_pkg::btn_events_t        events;
    tetris_pkg::piece_t             candidate;
    tetris_pkg::piece_t             piece;
    logic                           piece_active;
    logic                           fits;
    logic                           lock_req;
    logic                           clear_req;
    logic                           board_clear;
    logic [tetris_pkg::SCORE_W-1:0] score;

    button_conditioner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_button_conditioner (
        .clk        (clk),
        .reset      (reset),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_rotate (btn_rotate),
        .btn_drop   (btn_drop),
        .events     (events)
    );

    game_control #(
        .GRAVITY_CYCLES (GRAVITY_CYCLES)
    ) u_game_control (
        .clk          (clk),
        .reset        (reset),
        .events       (events),
        .fits         (fits),
        .win          (score_win),
        .candidate    (candidate),
        .lock_req     (lock_req),
        .clear_req    (clear_req),
        .board_clear  (board_clear),
        .piece        (piece),
        .piece_active (piece_active)
    );

    playfield u_playfield (
        .clk         (clk),
        .reset       (reset),
        .candidate   (candidate),
        .lock_req    (lock_req),
        .clear_req   (clear_req),
        .board_clear (board_clear),
        .view_row    (row_sel),
        .fits        (fits),
        .score       (score),
        .win         (score_win),
        .view_locked (locked_row)
    );

    row_view u_row_view (
        .piece        (piece),
        .piece_active (piece_active),
        .row_sel      (row_sel),
        .active_row   (active_row)
    );

    score_display #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_score_display (
        .clk   (clk),
        .reset (reset),
        .score (score),
        .seg   (seg),
        .an    (an)
    );

endmodule

// File: dv/tetris_properties.sv
`timescale 1ns/100ps

module tetris_properties (
    input logic               clk,
    input logic               reset,
    input logic               lock_req,
    input logic               clear_req,
    input logic               board_clear,
    input logic               clear_pending,
    input tetris_pkg::piece_t piece
);

    // one clear pulse right after each lock
    lock_then_clear: assert property (@(posedge clk) disable iff (reset)
        lock_req |=> (clear_req && !lock_req) ##1 !clear_req)
        else $error("clear_req did not follow lock_req as a single pulse");

    no_clear_with_lock: assert property (@(posedge clk) disable iff (reset)
        !(board_clear && lock_req))
        else $error("board_clear raised together with lock_req");

    // piece frozen across the compaction cycle
    hold_during_clear: assert property (@(posedge clk) disable iff (reset)
        clear_pending |=> $stable(piece))
        else $error("piece moved while a row clear was pending");

endmodule

bind game_control tetris_properties i_tetris_properties (
    .clk           (clk),
    .reset         (reset),
    .lock_req      (lock_req),
    .clear_req     (clear_req),
    .board_clear   (board_clear),
    .clear_pending (clear_pending),
    .piece         (piece)
);

// File: dv/tetris_tb.sv
`timescale 1ns/100ps

module tetris_tb;

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int GRAVITY_CYCLES  = 64;
    localparam int SCAN_CYCLES     = 8;
    localparam int POLL_TIMEOUT    = 40000;

    logic                         clk;
    logic                         reset;
    logic                         btn_left;
    logic                         btn_right;
    logic                         btn_rotate;
    logic                         btn_drop;
    logic [tetris_pkg::ROW_W-1:0] row_sel;
    tetris_pkg::row_mask_t        locked_row;
    tetris_pkg::row_mask_t        active_row;
    logic [6:0]                   seg;
    logic [1:0]                   an;
    logic                         score_win;

    int                    cyc;
    int                    exp_rows[$];
    tetris_pkg::row_mask_t exp_locked[$];
    tetris_pkg::row_mask_t exp_active[$];

    tetris_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .GRAVITY_CYCLES  (GRAVITY_CYCLES),
        .SCAN_CYCLES     (SCAN_CYCLES)
    ) i_tetris_top (
        .clk        (clk),
        .reset      (reset),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_rotate (btn_rotate),
        .btn_drop   (btn_drop),
        .row_sel    (row_sel),
        .locked_row (locked_row),
        .active_row (active_row),
        .seg        (seg),
        .an         (an),
        .score_win  (score_win)
    );

    always #5 clk = ~clk;

    // tracks the gravity counter phase
    always @(posedge clk) begin
        if (reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // active-low segments, bit order g f e d c b a
    function automatic logic [6:0] seven_seg_pattern(input int d);
        logic [6:0] p;
        case (d)
            0:       p = 7'b1000000;
            1:       p = 7'b1111001;
            2:       p = 7'b0100100;
            3:       p = 7'b0110000;
            4:       p = 7'b0011001;
            5:       p = 7'b0010010;
            6:       p = 7'b0000010;
            7:       p = 7'b1111000;
            8:       p = 7'b0000000;
            default: p = 7'b0010000;
        endcase
        return p;
    endfunction

    // presses are kept clear of the gravity tick, which would win
    task automatic hold_button(input byte btn, input int ticks);
        int k;
        for (k = 0; k < 2 * GRAVITY_CYCLES; k++) begin
            @(posedge clk);
            #1;
            if ((cyc % GRAVITY_CYCLES) >= 8 && (cyc % GRAVITY_CYCLES) <= 40) begin
                break;
            end
        end
        if (k == 2 * GRAVITY_CYCLES) begin
            stop_with_failure("timed out waiting for a safe point to press a button");
        end
        case (btn)
            "L":     btn_left = 1'b1;
            "R":     btn_right = 1'b1;
            "T":     btn_rotate = 1'b1;
            "D":     btn_drop = 1'b1;
            default: stop_with_failure("golden file names an unknown button");
        endcase
        repeat (ticks * DEBOUNCE_CYCLES) @(posedge clk);
        #1;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        btn_rotate = 1'b0;
        btn_drop   = 1'b0;
        // three released ticks so the next press is a fresh edge
        repeat (3 * DEBOUNCE_CYCLES) @(posedge clk);
        #1;
    endtask

    task automatic wait_digit(input logic [1:0] an_val, input int d);
        int k;
        for (k = 0; k < 4 * SCAN_CYCLES; k++) begin
            @(posedge clk);
            #1;
            // exactly one digit enabled at any time
            assert (an === 2'b10 || an === 2'b01) else begin
                stop_with_failure($sformatf("[FAIL] %0t: an=%b enables no single digit",
                                            $time, an));
            end
            if (an === an_val) begin
                break;
            end
        end
        if (k == 4 * SCAN_CYCLES) begin
            stop_with_failure("timed out waiting for a digit to be enabled");
        end
        assert (seg === seven_seg_pattern(d)) else begin
            stop_with_failure($sformatf("[FAIL] %0t: digit on an=%b expected %0d, seg=%b",
                                        $time, an_val, d, seg));
        end
    endtask

    task automatic check_state(input int tens, input int ones);
        int  t;
        bit  ok;
        bit  exp_win;
        int  bad_row;
        tetris_pkg::row_mask_t bad_l;
        tetris_pkg::row_mask_t bad_a;
        ok = 1'b0;
        exp_win = ((tens * 10 + ones) == tetris_pkg::MAX_SCORE);
        bad_row = 0;
        bad_l = '0;
        bad_a = '0;
        for (t = 0; t < POLL_TIMEOUT && !ok; t++) begin
            @(posedge clk);
            #1;
            ok = 1'b1;
            foreach (exp_rows[i]) begin
                row_sel = exp_rows[i];
                #0.5;
                if (ok && (locked_row !== exp_locked[i] || active_row !== exp_active[i])) begin
                    ok = 1'b0;
                    bad_row = exp_rows[i];
                    bad_l = locked_row;
                    bad_a = active_row;
                end
            end
        end
        assert (ok) else begin
            stop_with_failure($sformatf("[FAIL] %0t: row %0d never matched, locked=%h active=%h",
                                        $time, bad_row, bad_l, bad_a));
        end
        wait_digit(2'b10, ones);
        wait_digit(2'b01, tens);
        // win flag is set only at the maximum score
        assert (score_win === exp_win) else begin
            stop_with_failure($sformatf("[FAIL] %0t: score_win=%b for score %0d%0d",
                                        $time, score_win, tens, ones));
        end
        exp_rows.delete();
        exp_locked.delete();
        exp_active.delete();
    endtask

    initial begin
        int                    fd;
        int                    n;
        string                 line;
        byte                   btn;
        int                    ticks;
        int                    row;
        int                    tens;
        int                    ones;
        tetris_pkg::row_mask_t lk;
        tetris_pkg::row_mask_t ac;
        clk        = 1'b0;
        reset      = 1'b1;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        btn_rotate = 1'b0;
        btn_drop   = 1'b0;
        row_sel    = '0;
        fd = $fopen("dv/tetris_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open the golden file");
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n < 2 || line[0] == "#") begin
                continue;
            end
            case (line[0])
                "P": begin
                    n = $sscanf(line, "P %c %d", btn, ticks);
                    if (n != 2) begin
                        stop_with_failure("golden file has a bad button line");
                    end
                    hold_button(btn, ticks);
                end
                "E": begin
                    n = $sscanf(line, "E %d %h %h", row, lk, ac);
                    if (n != 3) begin
                        stop_with_failure("golden file has a bad row line");
                    end
                    exp_rows.push_back(row);
                    exp_locked.push_back(lk);
                    exp_active.push_back(ac);
                end
                "C": begin
                    n = $sscanf(line, "C %d %d", tens, ones);
                    if (n != 2) begin
                        stop_with_failure("golden file has a bad score line");
                    end
                    check_state(tens, ones);
                end
                default: stop_with_failure("golden file has a line that cannot be read");
            endcase
        end
        $fclose(fd);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: dv/tetris_golden.txt
# P <button L|R|T|D> <hold ticks> ; E <row> <locked hex> <active hex>
# C <tens> <ones> waits until all E rows match, then checks the score digits
E 0 000 000
E 14 000 000
C 0 0
E 0 000 0F0
C 0 0
P L 2
P L 2
P L 2
P L 2
P L 2
E 14 00F 000
C 0 0
E 0 000 030
E 1 000 060
C 0 0
P L 2
P L 2
P L 2
P L 2
E 12 003 000
E 13 006 000
E 14 00F 000
C 0 0
E 0 000 060
E 1 000 060
C 0 0
P L 2
P T 2
P D 4
E 13 036 000
E 14 03F 000
C 0 0
E 0 000 0F0
C 0 0
E 1 000 0F0
C 0 0
P T 2
E 2 000 020
E 3 000 020
E 4 000 020
C 0 0
P T 2
P R 2
P R 2
P R 2
E 12 000 000
E 13 003 000
E 14 036 000
C 0 1
E 13 000 000
E 14 000 000
C 0 0

// File: files.f
hw/tetris_pkg.sv
hw/button_conditioner.sv
hw/piece_cells.sv
hw/playfield.sv
hw/game_control.sv
hw/row_view.sv
hw/score_display.sv
hw/tetris_top.sv
dv/tetris_properties.sv
dv/tetris_tb.sv

// File: Bender.yml
package:
  name: tetris

sources:
  - hw/tetris_pkg.sv
  - hw/button_conditioner.sv
  - hw/piece_cells.sv
  - hw/playfield.sv
  - hw/game_control.sv
  - hw/row_view.sv
  - hw/score_display.sv
  - hw/tetris_top.sv
  - target: test
    files:
      - dv/tetris_properties.sv
      - dv/tetris_tb.sv
